//--- all.f
+incdir+source
source/alarm_puzzle_pkg.sv
source/second_timer.sv
source/alarm_sequencer.sv
source/puzzle_control.sv
source/puzzle_datapath.sv
source/alarm_puzzle_top.sv
test/tb_clock_gen.sv
test/alarm_puzzle_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the alarm puzzle testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f all.f \
    --top-module alarm_puzzle_tb \
    -o sim_alarm_puzzle

./obj_dir/sim_alarm_puzzle | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"

//--- source/alarm_puzzle_params.svh
`ifndef ALARM_PUZZLE_PARAMS_SVH
`define ALARM_PUZZLE_PARAMS_SVH

// operands, results and target share one width
`define ALARM_WORD_WIDTH 8

// clocks per timer second, small for simulation
`define ALARM_TICKS_PER_SECOND 8

// seconds run 0 to 99
`define ALARM_SECONDS_WRAP 100

// quotient for a zero divisor
`define ALARM_DIV_ZERO 255

`endif

//--- source/alarm_puzzle_pkg.sv
`default_nettype none

`include "alarm_puzzle_params.svh"

package alarm_puzzle_pkg;

    typedef logic [`ALARM_WORD_WIDTH-1:0] word_t;

    typedef logic [$clog2(`ALARM_SECONDS_WRAP)-1:0] seconds_t; // 7 bits for 0..99

    // alu input select
    typedef enum logic [1:0] {
        SEL_X = 2'd0,
        SEL_Y = 2'd1,
        SEL_Z = 2'd2
    } operand_sel_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_MUL = 2'd1,
        ALU_DIV = 2'd2
    } alu_op_e;

    // which micro-program a puzzle runs
    typedef enum logic {
        EQ_SQUARE_SUM = 1'b0, // y/z + (x/z)^2
        EQ_CUBIC_MIX  = 1'b1  // x*x*z + x*y
    } puzzle_equation_e;

    // top level sequencer
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        PUZZLE_1 = 2'd1,
        PUZZLE_2 = 2'd2,
        DONE     = 2'd3
    } seq_state_e;

    // per-puzzle control
    typedef enum logic [3:0] {
        LOAD_X, X_WAIT, LOAD_Y, Y_WAIT, LOAD_Z, Z_WAIT,
        CYCLE_0, CYCLE_1, CYCLE_2, CYCLE_3,
        COMPARE, COMPLETE, RESTART
    } puzzle_state_e;

endpackage

`default_nettype wire

//--- source/alarm_puzzle_top.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_puzzle_top (
    input  logic                      Clock,
    input  logic                      rst_n,
    input  logic                      start,
    input  logic                      go,
    input  alarm_puzzle_pkg::word_t    data_in,
    output alarm_puzzle_pkg::seconds_t seconds,
    output logic                      solved_1,
    output logic                      solved_2,
    output logic                      done,
    output logic                      wrong
);
    import alarm_puzzle_pkg::*;

    logic enable_1;
    logic enable_2;
    logic wrong_1;
    logic wrong_2;

    // puzzle 1 control to datapath
    logic ld_x_1, ld_y_1, ld_z_1, ld_target_1, ld_result_1, use_alu_1, clear_1, match_1;
    operand_sel_e sel_a_1, sel_b_1;
    alu_op_e      alu_op_1;

    // puzzle 2 control to datapath
    logic ld_x_2, ld_y_2, ld_z_2, ld_target_2, ld_result_2, use_alu_2, clear_2, match_2;
    operand_sel_e sel_a_2, sel_b_2;
    alu_op_e      alu_op_2;

    second_timer u_timer (
        .Clock   (Clock),
        .rst_n   (rst_n),
        .seconds (seconds)
    );

    alarm_sequencer u_sequencer (
        .Clock    (Clock),
        .rst_n    (rst_n),
        .start    (start),
        .solved_1 (solved_1),
        .solved_2 (solved_2),
        .enable_1 (enable_1),
        .enable_2 (enable_2),
        .done     (done)
    );

    puzzle_control #(.EQUATION(EQ_SQUARE_SUM)) u_control_1 (
        .Clock (Clock), .rst_n (rst_n), .enable (enable_1), .go (go), .match (match_1),
        .ld_x (ld_x_1), .ld_y (ld_y_1), .ld_z (ld_z_1), .ld_target (ld_target_1),
        .ld_result (ld_result_1), .use_alu (use_alu_1), .clear (clear_1),
        .solved (solved_1), .wrong (wrong_1),
        .sel_a (sel_a_1), .sel_b (sel_b_1), .alu_op (alu_op_1)
    );

    puzzle_datapath u_datapath_1 (
        .Clock (Clock), .rst_n (rst_n), .clear (clear_1),
        .ld_x (ld_x_1), .ld_y (ld_y_1), .ld_z (ld_z_1), .ld_target (ld_target_1),
        .ld_result (ld_result_1), .use_alu (use_alu_1),
        .data_in (data_in), .seconds (seconds),
        .sel_a (sel_a_1), .sel_b (sel_b_1), .alu_op (alu_op_1), .match (match_1)
    );

    puzzle_control #(.EQUATION(EQ_CUBIC_MIX)) u_control_2 (
        .Clock (Clock), .rst_n (rst_n), .enable (enable_2), .go (go), .match (match_2),
        .ld_x (ld_x_2), .ld_y (ld_y_2), .ld_z (ld_z_2), .ld_target (ld_target_2),
        .ld_result (ld_result_2), .use_alu (use_alu_2), .clear (clear_2),
        .solved (solved_2), .wrong (wrong_2),
        .sel_a (sel_a_2), .sel_b (sel_b_2), .alu_op (alu_op_2)
    );

    puzzle_datapath u_datapath_2 (
        .Clock (Clock), .rst_n (rst_n), .clear (clear_2),
        .ld_x (ld_x_2), .ld_y (ld_y_2), .ld_z (ld_z_2), .ld_target (ld_target_2),
        .ld_result (ld_result_2), .use_alu (use_alu_2),
        .data_in (data_in), .seconds (seconds),
        .sel_a (sel_a_2), .sel_b (sel_b_2), .alu_op (alu_op_2), .match (match_2)
    );

    assign wrong = wrong_1 | wrong_2; // only one puzzle takes presses at a time

endmodule

`default_nettype wire

//--- source/alarm_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module alarm_sequencer (
    input  logic Clock,
    input  logic rst_n,
    input  logic start,
    input  logic solved_1,
    input  logic solved_2,
    output logic enable_1,
    output logic enable_2,
    output logic done
);
    import alarm_puzzle_pkg::*;

    seq_state_e state;
    seq_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start) begin
                    next_state = PUZZLE_1;
                end
            end
            PUZZLE_1: begin
                if (solved_1) begin
                    next_state = PUZZLE_2;
                end
            end
            PUZZLE_2: begin
                if (solved_2) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                if (!start) begin
                    next_state = IDLE; // switch off to rearm
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // enables stay up through DONE so solved flags remain visible
    assign enable_1 = (state != IDLE);
    assign enable_2 = (state == PUZZLE_2) || (state == DONE);
    assign done     = (state == DONE);

endmodule

`default_nettype wire

//--- source/puzzle_control.sv
`timescale 1ns/1ps
`default_nettype none

module puzzle_control #(
    parameter alarm_puzzle_pkg::puzzle_equation_e EQUATION = alarm_puzzle_pkg::EQ_SQUARE_SUM
) (
    input  logic                          Clock,
    input  logic                          rst_n,
    input  logic                          enable,
    input  logic                          go,
    input  logic                          match,
    output logic                          ld_x,
    output logic                          ld_y,
    output logic                          ld_z,
    output logic                          ld_target,
    output logic                          ld_result,
    output logic                          use_alu,
    output logic                          clear,
    output logic                          solved,
    output logic                          wrong,
    output alarm_puzzle_pkg::operand_sel_e sel_a,
    output alarm_puzzle_pkg::operand_sel_e sel_b,
    output alarm_puzzle_pkg::alu_op_e      alu_op
);
    import alarm_puzzle_pkg::*;

    puzzle_state_e state;
    puzzle_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            LOAD_X:   next_state = go ? X_WAIT : LOAD_X;
            X_WAIT:   next_state = go ? X_WAIT : LOAD_Y;  // wait for release
            LOAD_Y:   next_state = go ? Y_WAIT : LOAD_Y;
            Y_WAIT:   next_state = go ? Y_WAIT : LOAD_Z;
            LOAD_Z:   next_state = go ? Z_WAIT : LOAD_Z;
            Z_WAIT:   next_state = go ? Z_WAIT : CYCLE_0;
            CYCLE_0:  next_state = CYCLE_1;
            CYCLE_1:  next_state = CYCLE_2;
            CYCLE_2:  next_state = CYCLE_3;
            CYCLE_3:  next_state = COMPARE;
            COMPARE:  next_state = match ? COMPLETE : RESTART;
            COMPLETE: next_state = COMPLETE;              // held until disabled
            RESTART:  next_state = LOAD_X;
            default:  next_state = LOAD_X;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            state <= LOAD_X;
        end else if (!enable) begin
            state <= LOAD_X;
        end else begin
            state <= next_state;
        end
    end

    // datapath strobes and the micro-program
    always_comb begin
        ld_x      = 1'b0;
        ld_y      = 1'b0;
        ld_z      = 1'b0;
        ld_target = 1'b0;
        ld_result = 1'b0;
        use_alu   = 1'b0;
        sel_a     = SEL_X;
        sel_b     = SEL_X;
        alu_op    = ALU_ADD;
        case (state)
            LOAD_X: begin
                ld_x      = 1'b1;
                ld_target = 1'b1; // target follows the timer until x is taken
            end
            LOAD_Y: ld_y = 1'b1;
            LOAD_Z: ld_z = 1'b1;
            CYCLE_0: begin
                use_alu = 1'b1;
                sel_a   = SEL_X;
                if (EQUATION == EQ_SQUARE_SUM) begin
                    sel_b  = SEL_Z; // x = x/z
                    alu_op = ALU_DIV;
                    ld_x   = 1'b1;
                end else begin
                    sel_b  = SEL_Y; // y = x*y
                    alu_op = ALU_MUL;
                    ld_y   = 1'b1;
                end
            end
            CYCLE_1: begin
                use_alu = 1'b1; // x = x*x in both
                sel_a   = SEL_X;
                sel_b   = SEL_X;
                alu_op  = ALU_MUL;
                ld_x    = 1'b1;
            end
            CYCLE_2: begin
                use_alu = 1'b1;
                sel_b   = SEL_Z;
                if (EQUATION == EQ_SQUARE_SUM) begin
                    sel_a  = SEL_Y; // y = y/z
                    alu_op = ALU_DIV;
                    ld_y   = 1'b1;
                end else begin
                    sel_a  = SEL_X; // x = x*z
                    alu_op = ALU_MUL;
                    ld_x   = 1'b1;
                end
            end
            CYCLE_3: begin
                sel_a     = SEL_X; // result = x + y
                sel_b     = SEL_Y;
                alu_op    = ALU_ADD;
                ld_result = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign solved = enable && (state == COMPLETE); // drops as soon as the sequencer idles
    assign wrong  = (state == RESTART);
    assign clear  = !enable || (state == RESTART);

endmodule

`default_nettype wire

//--- source/puzzle_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "alarm_puzzle_params.svh"

module puzzle_datapath (
    input  logic                          Clock,
    input  logic                          rst_n,
    input  logic                          clear,
    input  logic                          ld_x,
    input  logic                          ld_y,
    input  logic                          ld_z,
    input  logic                          ld_target,
    input  logic                          ld_result,
    input  logic                          use_alu,
    input  alarm_puzzle_pkg::word_t        data_in,
    input  alarm_puzzle_pkg::seconds_t     seconds,
    input  alarm_puzzle_pkg::operand_sel_e sel_a,
    input  alarm_puzzle_pkg::operand_sel_e sel_b,
    input  alarm_puzzle_pkg::alu_op_e      alu_op,
    output logic                          match
);
    import alarm_puzzle_pkg::*;

    word_t x;
    word_t y;
    word_t z;
    word_t target;
    word_t result;
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;

    // operand registers, x and y double as alu scratch
    always_ff @(posedge Clock) begin
        if (ld_x) begin
            x <= use_alu ? alu_out : data_in;
        end
        if (ld_y) begin
            y <= use_alu ? alu_out : data_in;
        end
        if (ld_z) begin
            z <= data_in;
        end
    end

    always_ff @(posedge Clock) begin
        if (!rst_n || clear) begin
            target <= '0;
            result <= '0;
        end else begin
            if (ld_target) begin
                target <= word_t'(seconds); // zero-extended timer value
            end
            if (ld_result) begin
                result <= alu_out;
            end
        end
    end

    always_comb begin
        case (sel_a)
            SEL_X:   alu_a = x;
            SEL_Y:   alu_a = y;
            SEL_Z:   alu_a = z;
            default: alu_a = '0;
        endcase
        case (sel_b)
            SEL_X:   alu_b = x;
            SEL_Y:   alu_b = y;
            SEL_Z:   alu_b = z;
            default: alu_b = '0;
        endcase
    end

    // all results wrap modulo 2^width
    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = alu_a + alu_b;
            ALU_MUL: alu_out = alu_a * alu_b;
            ALU_DIV: begin
                if (alu_b == '0) begin
                    alu_out = word_t'(`ALARM_DIV_ZERO);
                end else begin
                    alu_out = alu_a / alu_b;
                end
            end
            default: alu_out = '0;
        endcase
    end

    assign match = (result == target);

endmodule

`default_nettype wire

//--- source/second_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "alarm_puzzle_params.svh"

module second_timer #(
    parameter int TICKS_PER_SECOND = `ALARM_TICKS_PER_SECOND
) (
    input  logic                      Clock,
    input  logic                      rst_n,
    output alarm_puzzle_pkg::seconds_t seconds
);
    import alarm_puzzle_pkg::*;

    localparam int PRESCALE_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;

    logic [PRESCALE_W-1:0] prescale;
    logic                  tick;

    assign tick = (prescale == PRESCALE_W'(TICKS_PER_SECOND - 1)); // last clock of a second

    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            prescale <= '0;
        end else if (tick) begin
            prescale <= '0;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    // wrapping seconds count
    always_ff @(posedge Clock) begin
        if (!rst_n) begin
            seconds <= '0;
        end else if (tick) begin
            if (seconds == seconds_t'(`ALARM_SECONDS_WRAP - 1)) begin
                seconds <= '0;
            end else begin
                seconds <= seconds + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/alarm_puzzle_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "alarm_puzzle_params.svh"

module alarm_puzzle_tb;

    localparam int ROUNDS       = 3;
    localparam int RESET_CYCLES = 10;
    localparam int WORD_W       = `ALARM_WORD_WIDTH;
    localparam int TICKS        = `ALARM_TICKS_PER_SECOND;
    localparam int WRAP         = `ALARM_SECONDS_WRAP;
    localparam int SEARCH_TRIES = 4000;
    localparam int CYCLE_LIMIT  = ROUNDS * 8 * 8 * 3 + RESET_CYCLES;

    logic              Clock;
    logic              rst_n;
    logic              start;
    logic              go;
    logic [WORD_W-1:0] data_in;
    logic [6:0]        seconds;
    logic              solved_1;
    logic              solved_2;
    logic              done;
    logic              wrong;

    integer seed;
    int     elapsed;        // edges counted since reset release
    int     cycle_count;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     wrong_count;
    int     seconds_errors;
    int     order_errors;

    tb_clock_gen clock_gen_inst (.Clock(Clock));

    alarm_puzzle_top alarm_puzzle_top_inst (
        .Clock    (Clock),
        .rst_n    (rst_n),
        .start    (start),
        .go       (go),
        .data_in  (data_in),
        .seconds  (seconds),
        .solved_1 (solved_1),
        .solved_2 (solved_2),
        .done     (done),
        .wrong    (wrong)
    );

    function automatic int model_seconds(input int cycles);
        model_seconds = (cycles / TICKS) % WRAP;
    endfunction

    function automatic int divide_word(input int a, input int b);
        if (b == 0) begin
            divide_word = `ALARM_DIV_ZERO;
        end else begin
            divide_word = a / b;
        end
    endfunction

    // puzzle 1 is y/z + (x/z)^2, puzzle 2 is x*x*z + x*y, before the mod 256
    function automatic int raw_answer(input bit cubic, input int x, input int y, input int z);
        int q;
        if (cubic) begin
            raw_answer = x * x * z + x * y;
        end else begin
            q = divide_word(x, z);
            raw_answer = q * q + divide_word(y, z);
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string text);
        $display("ERROR %s", text);
        errors++;
    endtask

    task automatic finish_test(input string name, input int failures);
        tests_run++;
        if (failures == 0) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, failures);
        end
    endtask

    // one clock, then the checks that hold on every cycle
    task automatic tick();
        int expected_seconds;
        @(negedge Clock);
        if (rst_n) begin
            elapsed++;
        end
        expected_seconds = model_seconds(elapsed);
        if (seconds !== 7'(expected_seconds)) begin
            seconds_errors++;
            report_mismatch("timer", expected_seconds, seconds);
        end
        if (wrong === 1'b1) begin
            wrong_count++;
        end
        if ((solved_2 === 1'b1 || done === 1'b1) && solved_1 !== 1'b1) begin
            order_errors++;
            report_failure("solved_2 or done is high while solved_1 is low");
        end
        if (done === 1'b1 && solved_2 !== 1'b1) begin
            order_errors++;
            report_failure("done is high while solved_2 is low");
        end
    endtask

    // go high 1..4 cycles, then low 1..4 cycles unless the caller takes over
    task automatic press_key(input logic [WORD_W-1:0] value, input bit last_operand);
        int hold;
        int gap;
        hold = 1 + ({$random(seed)} % 4);
        gap = 1 + ({$random(seed)} % 4);
        data_in = value;
        go = 1'b1;
        repeat (hold) tick();
        go = 1'b0;
        data_in = WORD_W'($random(seed)); // junk while released
        if (!last_operand) begin
            repeat (gap) tick();
        end
    endtask

    task automatic pick_operands(input bit cubic, input int target, input bit want_hit,
                                 output logic [WORD_W-1:0] x, output logic [WORD_W-1:0] y,
                                 output logic [WORD_W-1:0] z);
        int tries;
        int raw;
        bit found;
        found = 1'b0;
        tries = 0;
        while (!found && tries < SEARCH_TRIES) begin
            x = WORD_W'($random(seed));
            y = WORD_W'($random(seed));
            if (cubic) begin
                x = x | WORD_W'(16); // big enough to wrap
                z = WORD_W'($random(seed));
            end else begin
                z = WORD_W'({$random(seed)} % 17); // zero now and then
            end
            raw = raw_answer(cubic, x, y, z);
            if (want_hit) begin
                found = (raw % 256 == target) && (!cubic || raw >= 256);
            end else begin
                found = (raw % 256 != target);
            end
            tries++;
        end
        if (!found) begin
            x = cubic ? WORD_W'(1) : WORD_W'(0);
            z = cubic ? WORD_W'(0) : WORD_W'(1);
            y = WORD_W'(want_hit ? target : target + 1);
        end
    endtask

    task automatic run_puzzle(input bit cubic, input bit want_hit, input string name);
        logic [WORD_W-1:0] x;
        logic [WORD_W-1:0] y;
        logic [WORD_W-1:0] z;
        int target;
        int errors_before;
        int wrong_before;
        int step;
        logic flag;
        errors_before = errors;
        wrong_before = wrong_count;
        target = model_seconds(elapsed); // taken with x at the coming edge
        pick_operands(cubic, target, want_hit, x, y, z);
        press_key(x, 1'b0);
        press_key(y, 1'b0);
        press_key(z, 1'b1);
        for (step = 1; step <= 6; step++) begin
            tick();
            flag = cubic ? solved_2 : solved_1;
            if (step < 6 && (flag !== 1'b0 || wrong !== 1'b0)) begin
                report_failure({name, ": outcome seen before the compare finished"});
            end
        end
        flag = cubic ? solved_2 : solved_1;
        if (flag !== want_hit) begin
            report_mismatch({name, " solved"}, want_hit, flag);
        end
        if (wrong !== !want_hit) begin
            report_mismatch({name, " wrong"}, !want_hit, wrong);
        end
        if (cubic && want_hit && done !== 1'b0) begin
            report_failure({name, ": done rose together with solved_2"});
        end
        tick(); // sequencer reacts here
        if (wrong_count - wrong_before != (want_hit ? 0 : 1)) begin
            report_mismatch({name, " wrong pulses"}, want_hit ? 0 : 1,
                            wrong_count - wrong_before);
        end
        if (cubic && want_hit && done !== 1'b1) begin
            report_mismatch({name, " done"}, 1, done);
        end
        finish_test(name, errors - errors_before);
    endtask

    // watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge Clock);
            cycle_count++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int r;
        int errors_before;
        seed = 79655;
        elapsed = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        wrong_count = 0;
        seconds_errors = 0;
        order_errors = 0;
        rst_n = 1'b0;
        start = 1'b0;
        go = 1'b0;
        data_in = '0;
        @(posedge Clock); // reset is seen from the first rising edge on

        errors_before = errors;
        repeat (RESET_CYCLES) tick();
        if (done !== 1'b0 || solved_1 !== 1'b0 || solved_2 !== 1'b0 || wrong !== 1'b0) begin
            report_failure("status outputs are not low during reset");
        end
        rst_n = 1'b1;
        tick();
        if (done !== 1'b0 || solved_1 !== 1'b0 || solved_2 !== 1'b0 || wrong !== 1'b0) begin
            report_failure("status outputs are not low after reset");
        end
        finish_test("reset", errors - errors_before);

        for (r = 0; r < ROUNDS; r++) begin
            start = 1'b1;
            tick(); // idle to puzzle 1
            run_puzzle(1'b0, 1'b0, $sformatf("round%0d_wrong_p1", r));
            run_puzzle(1'b0, 1'b1, $sformatf("round%0d_solve_p1", r));
            run_puzzle(1'b1, 1'b0, $sformatf("round%0d_wrong_p2", r));
            run_puzzle(1'b1, 1'b1, $sformatf("round%0d_solve_p2", r));

            errors_before = errors;
            start = 1'b0;
            tick(); // done and both solved flags drop together
            if (done !== 1'b0) begin
                report_mismatch($sformatf("round%0d_idle done", r), 0, done);
            end
            if (solved_1 !== 1'b0) begin
                report_mismatch($sformatf("round%0d_idle solved_1", r), 0, solved_1);
            end
            if (solved_2 !== 1'b0) begin
                report_mismatch($sformatf("round%0d_idle solved_2", r), 0, solved_2);
            end
            finish_test($sformatf("round%0d_idle", r), errors - errors_before);
        end

        finish_test("timer", seconds_errors);
        finish_test("ordering", order_errors);
        $display("summary: %0d tests, %0d failed, %0d errors, %0d cycles",
                 tests_run, tests_failed, errors, cycle_count);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic Clock
);

    initial begin
        Clock = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) Clock = ~Clock; // half period per toggle
        end
    end

endmodule

`default_nettype wire
